// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = spidergon_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/spidergon_pkg.sv
// spidergon shared types
`include "spidergon_settings.svh"

package spidergon_pkg;

	// node number on the ring
	typedef logic [`SPG_NODE_ID_WIDTH-1:0] node_id_t;

	// user data carried by a flit
	typedef logic [`SPG_PAYLOAD_WIDTH-1:0] payload_t;

	// single-flit packet
	typedef struct packed
	{
		node_id_t dest;
		node_id_t src;
		payload_t payload;
	} flit_t;

	// one direction of a link, valid strobe plus flit
	typedef struct packed
	{
		logic valid;
		flit_t flit;
	} link_t;

	// port names, the values index the per-port arrays
	// ring ports come first so that 0..2 covers the links
	typedef enum logic [1:0]
	{
		port_anticlockwise = 2'd0,
		port_clockwise = 2'd1,
		port_across = 2'd2,
		port_local = 2'd3
	} port_dir_t;

endpackage

// File: common/spidergon_settings.svh
// spidergon network settings
`ifndef SPIDERGON_SETTINGS_SVH
`define SPIDERGON_SETTINGS_SVH

// number of nodes on the ring, a multiple of 4
`define SPG_NUM_NODES 8

// width of a node number
`define SPG_NODE_ID_WIDTH 3

// user payload bits, a flit is then 16 bits wide
`define SPG_PAYLOAD_WIDTH 10

// flits held by one input buffer
`define SPG_BUFFER_DEPTH 2

`endif

// File: flist.f
+incdir+common
common/spidergon_pkg.sv
node/flit_buffer.sv
node/spidergon_route.sv
node/spidergon_router.sv
src/spidergon_top.sv
test/spidergon_chk.sv
test/spidergon_tb.sv

// File: node/flit_buffer.sv
// input flit FIFO
`timescale 1ns/1ps
`include "spidergon_settings.svh"

module flit_buffer
	import spidergon_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic write,
	input flit_t write_flit,
	input logic read,
	output logic head_valid,
	output flit_t head_flit,
	output logic full
);

	localparam int DEPTH = `SPG_BUFFER_DEPTH;
	localparam int PTR_WIDTH = $clog2(DEPTH);

	flit_t mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH:0] count;

	// storage
	always_ff @(posedge clk)
	begin
		if (write)
			mem[wr_ptr] <= write_flit;
	end

	// pointers wrap at the depth, which need not be a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (write)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (read)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (write && !read)
				count <= count + 1'b1;
			else if (read && !write)
				count <= count - 1'b1;
		end
	end

	assign head_valid = (count != '0);
	assign head_flit = mem[rd_ptr];
	assign full = (count == (PTR_WIDTH + 1)'(DEPTH));

endmodule

// File: node/spidergon_route.sv
// spidergon shortest-path route
`timescale 1ns/1ps
`include "spidergon_settings.svh"

module spidergon_route
	import spidergon_pkg::*;
#(
	parameter int NODE_ID = 0
)
(
	input node_id_t dest,
	output port_dir_t out_port
);

	localparam int NUM_NODES = `SPG_NUM_NODES;
	localparam int QUARTER = NUM_NODES / 4;

	// clockwise hop count from this node to the destination
	int distance;

	always_comb
	begin
		distance = int'(dest) - NODE_ID;
		if (distance < 0)
			distance = distance + NUM_NODES;
	end

	// near neighbours go round the ring, far ones take the across link first
	always_comb
	begin
		if (distance == 0)
			out_port = port_local;
		else if (distance <= QUARTER)
			out_port = port_clockwise;
		else if (distance >= NUM_NODES - QUARTER)
			out_port = port_anticlockwise;
		else
			out_port = port_across;
	end

endmodule

// File: node/spidergon_router.sv
// spidergon node router
`timescale 1ns/1ps

module spidergon_router
	import spidergon_pkg::*;
#(
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input link_t link_in [port_anticlockwise:port_across],
	output link_t link_out [port_anticlockwise:port_across],
	output logic full_in [port_anticlockwise:port_across],
	input logic full_out [port_anticlockwise:port_across],
	input link_t inject,
	output logic inject_full,
	output link_t eject
);

	// three ring ports plus the local port, on both sides
	localparam int NUM_PORTS = 4;
	localparam int IDX_WIDTH = $bits(port_dir_t);

	logic [NUM_PORTS-1:0] buf_write;
	flit_t buf_write_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] buf_read;
	logic [NUM_PORTS-1:0] head_valid;
	flit_t head_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] buf_full;
	port_dir_t head_port [NUM_PORTS];

	// per output, indexed by input
	logic [NUM_PORTS-1:0] req [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant [NUM_PORTS];
	logic [IDX_WIDTH-1:0] rr_ptr [NUM_PORTS];

	logic [NUM_PORTS-1:0] out_enable;
	logic [NUM_PORTS-1:0] out_valid;
	flit_t out_flit [NUM_PORTS];

	// input side: buffer and route decision per port
	for (genvar i = 0; i < NUM_PORTS; i++)
	begin : g_input
		if (i == port_local)
		begin : g_local
			// the environment holds its flit while the buffer is full
			assign buf_write[i] = inject.valid && !buf_full[i];
			assign buf_write_flit[i] = inject.flit;
			assign inject_full = buf_full[i];
		end
		else
		begin : g_ring
			// the upstream node already checked our full level
			assign buf_write[i] = link_in[i].valid;
			assign buf_write_flit[i] = link_in[i].flit;
			assign full_in[i] = buf_full[i];
		end

		flit_buffer u_buffer
		(
			.clk(clk),
			.reset(reset),
			.write(buf_write[i]),
			.write_flit(buf_write_flit[i]),
			.read(buf_read[i]),
			.head_valid(head_valid[i]),
			.head_flit(head_flit[i]),
			.full(buf_full[i])
		);

		spidergon_route #(.NODE_ID(NODE_ID)) u_route
		(
			.dest(head_flit[i].dest),
			.out_port(head_port[i])
		);
	end

	// every buffer head asks for exactly one output
	always_comb
	begin
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			for (int i = 0; i < NUM_PORTS; i++)
				req[o][i] = head_valid[i] && (int'(head_port[i]) == o);
		end
	end

	// round-robin search starting at the pointer of each output
	always_comb
	begin
		logic [IDX_WIDTH-1:0] idx;

		for (int o = 0; o < NUM_PORTS; o++)
		begin
			grant[o] = '0;
			for (int j = 0; j < NUM_PORTS; j++)
			begin
				idx = rr_ptr[o] + IDX_WIDTH'(j);
				if (grant[o] == '0 && req[o][idx] && out_enable[o])
					grant[o][idx] = 1'b1;
			end
		end
	end

	// a granted head leaves its buffer on the same edge that loads the output
	always_comb
	begin
		buf_read = '0;
		for (int o = 0; o < NUM_PORTS; o++)
			buf_read = buf_read | grant[o];
	end

	// output valids and arbiter pointers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= '0;
			for (int o = 0; o < NUM_PORTS; o++)
				rr_ptr[o] <= '0;
		end
		else
		begin
			for (int o = 0; o < NUM_PORTS; o++)
			begin
				out_valid[o] <= |grant[o];
				// winner drops to lowest priority
				for (int i = 0; i < NUM_PORTS; i++)
				begin
					if (grant[o][i])
						rr_ptr[o] <= IDX_WIDTH'(i + 1);
				end
			end
		end
	end

	// output flit registers
	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			for (int i = 0; i < NUM_PORTS; i++)
			begin
				if (grant[o][i])
					out_flit[o] <= head_flit[i];
			end
		end
	end

	// output side: ejection never stalls, ring links follow on/off flow control
	for (genvar o = 0; o < NUM_PORTS; o++)
	begin : g_output
		if (o == port_local)
		begin : g_eject
			assign out_enable[o] = 1'b1;
			assign eject.valid = out_valid[o];
			assign eject.flit = out_flit[o];
		end
		else
		begin : g_link
			// at most one flit in flight per link, so the full level
			// seen here already counts everything we sent
			assign out_enable[o] = !full_out[o] && !out_valid[o];
			assign link_out[o].valid = out_valid[o];
			assign link_out[o].flit = out_flit[o];
		end
	end

endmodule

// File: src/spidergon_top.sv
// spidergon network top
`timescale 1ns/1ps
`include "spidergon_settings.svh"

module spidergon_top
	import spidergon_pkg::*;
(
	input logic clk,
	input logic reset,
	input link_t inject [`SPG_NUM_NODES],
	output logic inject_full [`SPG_NUM_NODES],
	output link_t eject [`SPG_NUM_NODES]
);

	localparam int NUM_NODES = `SPG_NUM_NODES;
	localparam int HALF = NUM_NODES / 2;

	// per node, per ring port
	link_t ring_in [NUM_NODES][port_anticlockwise:port_across];
	link_t ring_out [NUM_NODES][port_anticlockwise:port_across];
	logic full_in [NUM_NODES][port_anticlockwise:port_across];
	logic full_out [NUM_NODES][port_anticlockwise:port_across];

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		localparam int NEXT = (n + 1) % NUM_NODES;
		localparam int PREV = (n + NUM_NODES - 1) % NUM_NODES;
		localparam int OPPOSITE = (n + HALF) % NUM_NODES;

		// clockwise link from n-1 arrives on our anticlockwise input
		assign ring_in[n][port_anticlockwise] = ring_out[PREV][port_clockwise];
		assign full_out[n][port_clockwise] = full_in[NEXT][port_anticlockwise];

		// anticlockwise link from n+1 arrives on our clockwise input
		assign ring_in[n][port_clockwise] = ring_out[NEXT][port_anticlockwise];
		assign full_out[n][port_anticlockwise] = full_in[PREV][port_clockwise];

		// across links pair node n with n+N/2 both ways
		assign ring_in[n][port_across] = ring_out[OPPOSITE][port_across];
		assign full_out[n][port_across] = full_in[OPPOSITE][port_across];

		spidergon_router #(.NODE_ID(n)) u_router
		(
			.clk(clk),
			.reset(reset),
			.link_in(ring_in[n]),
			.link_out(ring_out[n]),
			.full_in(full_in[n]),
			.full_out(full_out[n]),
			.inject(inject[n]),
			.inject_full(inject_full[n]),
			.eject(eject[n])
		);
	end

endmodule

// File: test/spidergon_chk.sv
// router protocol assertions
`timescale 1ns/1ps

module spidergon_chk
	import spidergon_pkg::*;
#(
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input link_t link_out [port_anticlockwise:port_across],
	input logic full_out [port_anticlockwise:port_across],
	input link_t eject
);

	logic any_valid;

	assign any_valid = link_out[port_anticlockwise].valid || link_out[port_clockwise].valid
		|| link_out[port_across].valid || eject.valid;

	// on/off flow control, a link never carries a flit into a full buffer
	for (genvar p = 0; p < 3; p++)
	begin : g_ring
		a_no_send_when_full: assert property (@(posedge clk) disable iff (reset)
			link_out[p].valid |-> !full_out[p])
		else
			$error("node %0d sends on port %0d while the receiver is full", NODE_ID, p);
	end

	// only flits addressed to this node leave on the local port
	a_eject_dest: assert property (@(posedge clk) disable iff (reset)
		eject.valid |-> (int'(eject.flit.dest) == NODE_ID))
	else
		$error("node %0d ejects a flit for node %0d", NODE_ID, eject.flit.dest);

	// outputs come out of reset idle
	a_idle_after_reset: assert property (@(posedge clk) reset |=> !any_valid)
	else
		$error("node %0d has a valid output right after reset", NODE_ID);

endmodule

bind spidergon_router spidergon_chk #(.NODE_ID(NODE_ID)) u_chk
(
	.clk(clk),
	.reset(reset),
	.link_out(link_out),
	.full_out(full_out),
	.eject(eject)
);

// File: test/spidergon_tb.sv
// spidergon network testbench
`timescale 1ns/1ps
`include "spidergon_settings.svh"

module spidergon_tb
	import spidergon_pkg::*;
;

	localparam int NUM_NODES = `SPG_NUM_NODES;
	localparam int ACCEPT_TIMEOUT = 1000;
	localparam int DRAIN_TIMEOUT = 4000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	link_t inject [NUM_NODES];
	logic inject_full [NUM_NODES];
	link_t eject [NUM_NODES];

	// expected flits, one queue per source and destination pair
	flit_t expected_q [NUM_NODES*NUM_NODES][$];
	int sent_count = 0;
	int received_count = 0;
	integer seed;
	logic saw_full;
	logic result_printed = 1'b0;

	spidergon_top dut0
	(
		.clk(clk),
		.reset(reset),
		.inject(inject),
		.inject_full(inject_full),
		.eject(eject)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		result_printed = 1'b1;
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
			abort_run("a checked value did not match");
		end
	endtask

	// a flit ejects at its destination and is not changed on the way
	function automatic int ref_eject(input flit_t injected, output flit_t shown);
		shown = injected;
		return int'(injected.dest);
	endfunction

	function automatic flit_t make_flit(input int src, input int dest, input payload_t payload);
		flit_t f;
		f.dest = node_id_t'(dest);
		f.src = node_id_t'(src);
		f.payload = payload;
		return f;
	endfunction

	// called a little after a rising edge, returns at the same point
	task automatic send_flit(input int node, input flit_t f);
		int waited;
		int at_node;
		flit_t shown;
		waited = 0;
		inject[node].flit = f;
		inject[node].valid = 1'b1;
		while (inject_full[node])
		begin
			if (waited >= ACCEPT_TIMEOUT)
				abort_run($sformatf("node %0d never accepted its flit", node));
			saw_full = 1'b1;
			@(posedge clk);
			#1;
			waited++;
		end
		// full is low here, so the next edge takes the flit
		at_node = ref_eject(f, shown);
		expected_q[int'(f.src)*NUM_NODES + at_node].push_back(shown);
		sent_count++;
		@(posedge clk);
		#1;
		inject[node].valid = 1'b0;
	endtask

	// back to back flits from one node, to one node or to random ones
	task automatic node_stream(input int node, input int count, input int hot_dest);
		int dest;
		for (int k = 0; k < count; k++)
		begin
			if (hot_dest < 0)
				dest = int'(node_id_t'($random(seed)));
			else
				dest = hot_dest;
			send_flit(node, make_flit(node, dest, payload_t'($random(seed))));
		end
	endtask

	task automatic all_nodes_stream(input int count, input int hot_dest);
		fork
			node_stream(0, count, hot_dest);
			node_stream(1, count, hot_dest);
			node_stream(2, count, hot_dest);
			node_stream(3, count, hot_dest);
			node_stream(4, count, hot_dest);
			node_stream(5, count, hot_dest);
			node_stream(6, count, hot_dest);
			node_stream(7, count, hot_dest);
		join
	endtask

	task automatic wait_drain(input string phase);
		int waited;
		waited = 0;
		while (sent_count != received_count)
		begin
			if (waited >= DRAIN_TIMEOUT)
				abort_run($sformatf("%s: flits still in the network after the timeout", phase));
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// scoreboard, ejections are sampled away from the rising edge
	always @(negedge clk)
	begin : compare_eject
		int key;
		flit_t got;
		flit_t expected;
		if (!reset)
		begin
			for (int n = 0; n < NUM_NODES; n++)
			begin
				if (eject[n].valid)
				begin
					got = eject[n].flit;
					key = int'(got.src)*NUM_NODES + n;
					if (expected_q[key].size() == 0)
						abort_run($sformatf("node %0d ejected a flit nobody sent: %h", n, got));
					else
					begin
						expected = expected_q[key].pop_front();
						received_count++;
						check_value($sformatf("eject[%0d].flit", n), 32'(got), 32'(expected));
					end
				end
			end
		end
	end

	initial
	begin : run
		int leftover;
		seed = 21;
		saw_full = 1'b0;
		for (int n = 0; n < NUM_NODES; n++)
			inject[n] = '0;

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// reset state
		for (int n = 0; n < NUM_NODES; n++)
		begin
			check_value($sformatf("eject[%0d].valid", n), 32'(eject[n].valid), 32'd0);
			check_value($sformatf("inject_full[%0d]", n), 32'(inject_full[n]), 32'd0);
		end

		// one packet per distance from node 0
		for (int d = 0; d < NUM_NODES; d++)
		begin
			send_flit(0, make_flit(0, d, payload_t'($random(seed))));
			wait_drain("distance");
		end

		// every source and destination pair
		for (int s = 0; s < NUM_NODES; s++)
		begin
			for (int d = 0; d < NUM_NODES; d++)
				send_flit(s, make_flit(s, d, payload_t'($random(seed))));
			wait_drain("all pairs");
		end

		// a fixed route keeps the order, across then clockwise
		node_stream(2, 24, 7);
		wait_drain("ordering");

		// hot spot traffic fills the buffers back to the sources
		saw_full = 1'b0;
		all_nodes_stream(16, 5);
		wait_drain("back-pressure");
		check_value("inject_full seen high", 32'(saw_full), 32'd1);

		all_nodes_stream(40, -1);
		wait_drain("random traffic");

		leftover = 0;
		for (int k = 0; k < NUM_NODES*NUM_NODES; k++)
			leftover = leftover + expected_q[k].size();

		result_printed = 1'b1;
		if (leftover == 0 && sent_count == received_count)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("%0d expected flits were never ejected", leftover);
			$display("Result: FAILED");
		end
		$finish;
	end

	// a run stopped by a failed assertion still ends with the verdict
	final
	begin
		if (!result_printed)
			$display("Result: FAILED");
	end

endmodule
